// File: Makefile
TOP := tb_rgb_led

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f compile.f --top-module $(TOP)

run: build
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TB PASSED"

lint:
	verilator --lint-only --timing -Wall -f compile.f --top-module $(TOP)

clean:
	rm -rf obj_dir

// File: compile.f
rtl/rgb_led_pkg.sv
rtl/color_regfile.sv
rtl/button_debounce.sv
rtl/pwm_timebase.sv
rtl/led_pwm_mixer.sv
rtl/rgb_led_top.sv
tb/rgb_led_sva.sv
tb/tb_rgb_led.sv

// File: rtl/button_debounce.sv
`timescale 1ns/100ps
module button_debounce #(
    parameter int DEBOUNCE_CYCLES = 50000
) (
    input  logic clk,
    input  logic rst,
    input  logic button,
    output logic step_pulse
);

    localparam int CNT_W = $clog2(DEBOUNCE_CYCLES + 1);

    logic [1:0]       sync_q;
    logic             level_q;
    logic [CNT_W-1:0] cnt_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sync_q     <= '0;
            level_q    <= 1'b0;
            cnt_q      <= '0;
            step_pulse <= 1'b0;
        end else begin
            sync_q     <= {sync_q[0], button};
            step_pulse <= 1'b0;
            if (sync_q[1] == level_q) begin
                // input agrees with the level, restart the window
                cnt_q <= '0;
            end else if (cnt_q == CNT_W'(DEBOUNCE_CYCLES)) begin
                level_q    <= sync_q[1];
                cnt_q      <= '0;
                // pulse only on the press, not on release
                step_pulse <= sync_q[1];
            end else begin
                cnt_q <= cnt_q + 1'b1;
            end
        end
    end

endmodule

// File: rtl/color_regfile.sv
`timescale 1ns/100ps
module color_regfile (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 cmd_valid,
    input  logic [1:0]                           channel,
    input  logic [3:0]                           address,
    input  logic [3:0]                           data,
    input  logic                                 step_pulse,
    output logic                                 cmd_ack,
    output logic [rgb_led_pkg::NUM_LEDS-1:0]     color_update,
    output rgb_led_pkg::rgb_color_u              rgb0,
    output rgb_led_pkg::rgb_color_u              rgb1,
    output rgb_led_pkg::rgb_color_u              rgb2,
    output rgb_led_pkg::rgb_color_u              rgb3
);

    rgb_led_pkg::rgb_color_u              color_q [rgb_led_pkg::NUM_LEDS];
    rgb_led_pkg::rgb_color_u              color_d [rgb_led_pkg::NUM_LEDS];
    logic [1:0]                           preset_idx_q [rgb_led_pkg::NUM_LEDS];
    logic [1:0]                           preset_idx_d [rgb_led_pkg::NUM_LEDS];
    logic [rgb_led_pkg::NUM_LEDS-1:0]     update_d;
    logic [rgb_led_pkg::NUM_LEDS-1:0]     chan_onehot;
    logic                                 busy_q;
    logic                                 accept;
    logic [2:0]                           nib_sel;
    logic [1:0]                           step_idx;

    // step wins over a command in the same cycle
    assign accept   = cmd_valid && !busy_q && !step_pulse;
    assign nib_sel  = 3'(4'd8 - address);
    assign step_idx = preset_idx_q[channel] + 2'd1;

    always_comb begin
        chan_onehot = '0;
        chan_onehot[channel] = 1'b1;
    end

    always_comb begin
        color_d      = color_q;
        preset_idx_d = preset_idx_q;
        update_d     = '0;

        if (step_pulse) begin
            // advance this LED through the table, 3 wraps to 0
            preset_idx_d[channel] = step_idx;
            color_d[channel]      = rgb_led_pkg::PRESET_COLORS[step_idx];
            update_d              = chan_onehot;
        end else if (accept) begin
            case (address)
                rgb_led_pkg::ADDR_PRESET_ALL: begin
                    for (int i = 0; i < rgb_led_pkg::NUM_LEDS; i++) begin
                        color_d[i] = rgb_led_pkg::PRESET_COLORS[i];
                    end
                    update_d = '1;
                end
                rgb_led_pkg::ADDR_RED_HI,
                rgb_led_pkg::ADDR_RED_LO,
                rgb_led_pkg::ADDR_GRN_HI,
                rgb_led_pkg::ADDR_GRN_LO,
                rgb_led_pkg::ADDR_BLU_HI,
                rgb_led_pkg::ADDR_BLU_LO: begin
                    color_d[channel].nib[nib_sel] = data;
                    update_d = chan_onehot;
                end
                default: begin
                    // acked, nothing written
                end
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < rgb_led_pkg::NUM_LEDS; i++) begin
                color_q[i]      <= rgb_led_pkg::PRESET_COLORS[i];
                preset_idx_q[i] <= 2'(i);
            end
            cmd_ack      <= 1'b0;
            color_update <= '0;
            busy_q       <= 1'b0;
        end else begin
            color_q      <= color_d;
            preset_idx_q <= preset_idx_d;
            cmd_ack      <= accept;
            color_update <= update_d;
            // blocks the next edge so a held valid is taken once
            busy_q       <= accept || step_pulse;
        end
    end

    assign rgb0 = color_q[0];
    assign rgb1 = color_q[1];
    assign rgb2 = color_q[2];
    assign rgb3 = color_q[3];

endmodule

// File: rtl/led_pwm_mixer.sv
`timescale 1ns/100ps
module led_pwm_mixer (
    input  logic                             clk,
    input  logic                             rst,
    input  rgb_led_pkg::rgb_color_u          rgb0,
    input  rgb_led_pkg::rgb_color_u          rgb1,
    input  rgb_led_pkg::rgb_color_u          rgb2,
    input  rgb_led_pkg::rgb_color_u          rgb3,
    input  logic [7:0]                       pwm_count,
    input  logic                             frame_start,
    output logic [rgb_led_pkg::NUM_LEDS-1:0] led_r,
    output logic [rgb_led_pkg::NUM_LEDS-1:0] led_g,
    output logic [rgb_led_pkg::NUM_LEDS-1:0] led_b
);

    rgb_led_pkg::rgb_color_u          color_in [rgb_led_pkg::NUM_LEDS];
    rgb_led_pkg::rgb_color_u          shadow_q [rgb_led_pkg::NUM_LEDS];
    rgb_led_pkg::rgb_color_u          shadow_d [rgb_led_pkg::NUM_LEDS];
    logic [rgb_led_pkg::NUM_LEDS-1:0] r_d;
    logic [rgb_led_pkg::NUM_LEDS-1:0] g_d;
    logic [rgb_led_pkg::NUM_LEDS-1:0] b_d;

    assign color_in[0] = rgb0;
    assign color_in[1] = rgb1;
    assign color_in[2] = rgb2;
    assign color_in[3] = rgb3;

    always_comb begin
        for (int i = 0; i < rgb_led_pkg::NUM_LEDS; i++) begin
            // new colors only at a frame boundary
            shadow_d[i] = frame_start ? color_in[i] : shadow_q[i];
            r_d[i] = pwm_count < shadow_d[i].bytes.red;
            g_d[i] = pwm_count < shadow_d[i].bytes.green;
            b_d[i] = pwm_count < shadow_d[i].bytes.blue;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < rgb_led_pkg::NUM_LEDS; i++) begin
                shadow_q[i] <= rgb_led_pkg::PRESET_COLORS[i];
            end
            led_r <= '0;
            led_g <= '0;
            led_b <= '0;
        end else begin
            shadow_q <= shadow_d;
            led_r    <= r_d;
            led_g    <= g_d;
            led_b    <= b_d;
        end
    end

endmodule

// File: rtl/pwm_timebase.sv
`timescale 1ns/100ps
module pwm_timebase #(
    parameter int PWM_DIV = 64
) (
    input  logic       clk,
    input  logic       rst,
    output logic [7:0] pwm_count,
    output logic       frame_start
);

    // one extra bit keeps the width nonzero for PWM_DIV of 1
    localparam int PRE_W = $clog2(PWM_DIV + 1);

    logic [PRE_W-1:0] pre_q;
    logic             tick;

    assign tick = (pre_q == PRE_W'(PWM_DIV - 1));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pre_q     <= '0;
            pwm_count <= 8'd0;
        end else begin
            if (tick) begin
                pre_q     <= '0;
                // 255 rolls over to 0
                pwm_count <= pwm_count + 8'd1;
            end else begin
                pre_q <= pre_q + 1'b1;
            end
        end
    end

    // first prescale cycle of count 0
    assign frame_start = (pwm_count == 8'd0) && (pre_q == '0);

endmodule

// File: rtl/rgb_led_pkg.sv
package rgb_led_pkg;

    // four LEDs, so a 2-bit channel field
    localparam int NUM_LEDS = 4;

    // one 24-bit color, seen as bytes by the mixer and as nibbles by the writes
    typedef union packed {
        struct packed {
            logic [7:0] red;
            logic [7:0] green;
            logic [7:0] blue;
        } bytes;
        // nibble 0 is the low blue nibble
        logic [5:0][3:0] nib;
    } rgb_color_u;

    // command addresses
    localparam logic [3:0] ADDR_PRESET_ALL = 4'd0;
    localparam logic [3:0] ADDR_RED_HI     = 4'd3;
    localparam logic [3:0] ADDR_RED_LO     = 4'd4;
    localparam logic [3:0] ADDR_GRN_HI     = 4'd5;
    localparam logic [3:0] ADDR_GRN_LO     = 4'd6;
    localparam logic [3:0] ADDR_BLU_HI     = 4'd7;
    localparam logic [3:0] ADDR_BLU_LO     = 4'd8;

    // preset table, index 0 in the low word
    localparam rgb_color_u [NUM_LEDS-1:0] PRESET_COLORS = {
        24'hFFFF00,
        24'h0000FF,
        24'h00FF00,
        24'hFF0000
    };

endpackage

// File: rtl/rgb_led_top.sv
`timescale 1ns/100ps
module rgb_led_top #(
    parameter int DEBOUNCE_CYCLES = 50000,
    parameter int PWM_DIV         = 64
) (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             button,
    input  logic                             cmd_valid,
    input  logic [1:0]                       channel,
    input  logic [3:0]                       address,
    input  logic [3:0]                       data,
    output logic                             cmd_ack,
    output logic [rgb_led_pkg::NUM_LEDS-1:0] color_update,
    output rgb_led_pkg::rgb_color_u          rgb0,
    output rgb_led_pkg::rgb_color_u          rgb1,
    output rgb_led_pkg::rgb_color_u          rgb2,
    output rgb_led_pkg::rgb_color_u          rgb3,
    output logic [rgb_led_pkg::NUM_LEDS-1:0] led_r,
    output logic [rgb_led_pkg::NUM_LEDS-1:0] led_g,
    output logic [rgb_led_pkg::NUM_LEDS-1:0] led_b
);

    logic       step_pulse;
    logic [7:0] pwm_count;
    logic       frame_start;

    button_debounce #(
        .DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)
    ) i_debounce (
        .clk        (clk),
        .rst        (rst),
        .button     (button),
        .step_pulse (step_pulse)
    );

    color_regfile i_regfile (
        .clk          (clk),
        .rst          (rst),
        .cmd_valid    (cmd_valid),
        .channel      (channel),
        .address      (address),
        .data         (data),
        .step_pulse   (step_pulse),
        .cmd_ack      (cmd_ack),
        .color_update (color_update),
        .rgb0         (rgb0),
        .rgb1         (rgb1),
        .rgb2         (rgb2),
        .rgb3         (rgb3)
    );

    pwm_timebase #(
        .PWM_DIV(PWM_DIV)
    ) i_timebase (
        .clk         (clk),
        .rst         (rst),
        .pwm_count   (pwm_count),
        .frame_start (frame_start)
    );

    led_pwm_mixer i_mixer (
        .clk         (clk),
        .rst         (rst),
        .rgb0        (rgb0),
        .rgb1        (rgb1),
        .rgb2        (rgb2),
        .rgb3        (rgb3),
        .pwm_count   (pwm_count),
        .frame_start (frame_start),
        .led_r       (led_r),
        .led_g       (led_g),
        .led_b       (led_b)
    );

endmodule

// File: tb/rgb_led_sva.sv
`timescale 1ns/100ps
module rgb_led_sva (
    input logic       clk,
    input logic       rst,
    input logic       cmd_ack,
    input logic       step_pulse,
    input logic [3:0] color_update
);

    property ack_one_cycle;
        @(posedge clk) disable iff (rst) cmd_ack |=> !cmd_ack;
    endproperty

    // every color change, by step or by write, is followed by a busy cycle
    property no_ack_when_busy;
        @(posedge clk) disable iff (rst) (color_update != 4'h0) |=> !cmd_ack;
    endproperty

    property update_legal;
        @(posedge clk) disable iff (rst) $onehot0(color_update) || (color_update == 4'hF);
    endproperty

    property step_one_cycle;
        @(posedge clk) disable iff (rst) step_pulse |=> !step_pulse;
    endproperty

    a_ack_one_cycle: assert property (ack_one_cycle)
        else $error("cmd_ack stayed high for more than one cycle");
    a_no_ack_when_busy: assert property (no_ack_when_busy)
        else $error("cmd_ack given in a busy cycle");
    a_update_legal: assert property (update_legal)
        else $error("color_update is neither one-hot, all ones nor zero");
    a_step_one_cycle: assert property (step_one_cycle)
        else $error("step_pulse stayed high for more than one cycle");

endmodule

bind color_regfile rgb_led_sva i_sva (
    .clk          (clk),
    .rst          (rst),
    .cmd_ack      (cmd_ack),
    .step_pulse   (step_pulse),
    .color_update (color_update)
);

// File: tb/tb_rgb_led.sv
`timescale 1ns/100ps
module tb_rgb_led;

    localparam int DEBOUNCE_CYCLES = 8;
    localparam int PWM_DIV         = 1;
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

    localparam logic [1:0] K_CMD    = 2'd0;
    localparam logic [1:0] K_PRESS  = 2'd1;
    localparam logic [1:0] K_GLITCH = 2'd2;
    localparam logic [1:0] K_DUTY   = 2'd3;

    // entry word is {kind, random data, channel, address, data}
    localparam int NUM_ENTRIES = 25;
    localparam logic [12:0] STIM [NUM_ENTRIES] = '{
        {K_CMD,    1'b0, 2'd0, rgb_led_pkg::ADDR_RED_HI,     4'h1},
        {K_CMD,    1'b0, 2'd0, rgb_led_pkg::ADDR_BLU_LO,     4'hA},
        {K_CMD,    1'b1, 2'd1, rgb_led_pkg::ADDR_GRN_HI,     4'h0},
        {K_CMD,    1'b1, 2'd1, rgb_led_pkg::ADDR_GRN_LO,     4'h0},
        {K_CMD,    1'b1, 2'd2, rgb_led_pkg::ADDR_BLU_HI,     4'h0},
        {K_CMD,    1'b1, 2'd3, rgb_led_pkg::ADDR_RED_LO,     4'h0},
        {K_CMD,    1'b0, 2'd2, rgb_led_pkg::ADDR_RED_HI,     4'h8},
        {K_CMD,    1'b0, 2'd3, rgb_led_pkg::ADDR_BLU_LO,     4'h3},
        {K_DUTY,   1'b0, 2'd0, 4'h0,                         4'h0},
        {K_CMD,    1'b0, 2'd1, 4'hF,                         4'h5},
        {K_CMD,    1'b0, 2'd0, 4'h1,                         4'hC},
        {K_CMD,    1'b0, 2'd2, rgb_led_pkg::ADDR_PRESET_ALL, 4'h0},
        {K_DUTY,   1'b0, 2'd0, 4'h0,                         4'h0},
        {K_PRESS,  1'b0, 2'd0, 4'h0,                         4'h0},
        {K_PRESS,  1'b0, 2'd3, 4'h0,                         4'h0},
        {K_GLITCH, 1'b0, 2'd1, 4'h0,                         4'h0},
        {K_PRESS,  1'b0, 2'd3, 4'h0,                         4'h0},
        {K_PRESS,  1'b0, 2'd2, 4'h0,                         4'h0},
        {K_PRESS,  1'b0, 2'd2, 4'h0,                         4'h0},
        {K_DUTY,   1'b0, 2'd0, 4'h0,                         4'h0},
        {K_CMD,    1'b1, 2'd2, rgb_led_pkg::ADDR_GRN_LO,     4'h0},
        {K_CMD,    1'b1, 2'd0, rgb_led_pkg::ADDR_RED_LO,     4'h0},
        {K_GLITCH, 1'b0, 2'd0, 4'h0,                         4'h0},
        {K_CMD,    1'b1, 2'd3, rgb_led_pkg::ADDR_BLU_HI,     4'h0},
        {K_DUTY,   1'b0, 2'd0, 4'h0,                         4'h0}
    };

    localparam int MAX_CYCLES = 2 * NUM_ENTRIES * (300 + 30);
    localparam logic [23:0] PRESET_REF [4] = '{24'hFF0000, 24'h00FF00, 24'h0000FF, 24'hFFFF00};

    logic clk;
    logic rst;
    logic button;
    logic cmd_valid;
    logic [1:0] channel;
    logic [3:0] address;
    logic [3:0] data;
    logic cmd_ack;
    logic [3:0] color_update;
    rgb_led_pkg::rgb_color_u rgb0;
    rgb_led_pkg::rgb_color_u rgb1;
    rgb_led_pkg::rgb_color_u rgb2;
    rgb_led_pkg::rgb_color_u rgb3;
    logic [3:0] led_r;
    logic [3:0] led_g;
    logic [3:0] led_b;

    logic [23:0] model_color [4];
    logic [1:0]  model_idx [4];
    logic [31:0] lfsr;
    logic [12:0] entry;
    logic [3:0]  cmd_data;
    bit          test_bad;
    int          tests_failed = 0;
    int          cycles = 0;
    int          ack_total = 0;
    int          upd_total = 0;
    logic [3:0]  upd_last = 4'h0;

    rgb_led_top #(
        .DEBOUNCE_CYCLES(DEBOUNCE_CYCLES),
        .PWM_DIV(PWM_DIV)
    ) i_dut (
        .clk(clk), .rst(rst), .button(button),
        .cmd_valid(cmd_valid), .channel(channel), .address(address), .data(data),
        .cmd_ack(cmd_ack), .color_update(color_update),
        .rgb0(rgb0), .rgb1(rgb1), .rgb2(rgb2), .rgb3(rgb3),
        .led_r(led_r), .led_g(led_g), .led_b(led_b)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // pulse counters, sampled just before each edge
    always @(posedge clk) begin
        if (!rst) begin
            ack_total <= ack_total + int'(cmd_ack);
            if (color_update != 4'h0) begin
                upd_total <= upd_total + 1;
                upd_last  <= color_update;
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("run aborted after %0d cycles, the tests did not finish", cycles);
            $display("TB FAILED");
            $finish;
        end
    end

    function automatic logic [3:0] rand_nibble();
        logic [3:0] nib;
        for (int b = 0; b < 4; b++) begin
            nib[b] = lfsr[0];
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ LFSR_TAPS) : (lfsr >> 1);
        end
        return nib;
    endfunction

    function automatic logic [23:0] dut_color(input int ch);
        case (ch)
            0:       return rgb0;
            1:       return rgb1;
            2:       return rgb2;
            default: return rgb3;
        endcase
    endfunction

    function automatic string kind_name(input logic [1:0] kind);
        case (kind)
            K_CMD:    return "command";
            K_PRESS:  return "press";
            K_GLITCH: return "glitch";
            default:  return "duty frame";
        endcase
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("mismatch at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
            test_bad = 1'b1;
        end
    endtask

    task automatic check_colors();
        for (int i = 0; i < 4; i++) begin
            check($sformatf("rgb%0d", i), 32'(dut_color(i)), 32'(model_color[i]));
        end
    endtask

    task automatic do_command(input logic [1:0] ch, input logic [3:0] addr, input logic [3:0] dat);
        logic [3:0] exp_upd;
        int a0;
        exp_upd = 4'b0001 << ch;
        if (addr == rgb_led_pkg::ADDR_PRESET_ALL) begin
            for (int i = 0; i < 4; i++) begin
                model_color[i] = PRESET_REF[i];
            end
            exp_upd = 4'hF;
        end else if (addr >= rgb_led_pkg::ADDR_RED_HI && addr <= rgb_led_pkg::ADDR_BLU_LO) begin
            model_color[ch][4*(8-int'(addr)) +: 4] = dat;
        end else begin
            exp_upd = 4'h0;
        end
        a0 = ack_total;
        cmd_valid = 1'b1;
        channel   = ch;
        address   = addr;
        data      = dat;
        do @(negedge clk); while (!cmd_ack);
        check("color_update", 32'(color_update), 32'(exp_upd));
        check_colors();
        // valid stays up through the busy cycle
        @(negedge clk);
        cmd_valid = 1'b0;
        check("cmd_ack", 32'(cmd_ack), 32'd0);
        repeat (2) @(negedge clk);
        check("cmd_ack pulse count", 32'(ack_total - a0), 32'd1);
        check_colors();
    endtask

    task automatic run_button(input logic [1:0] ch, input int hold, input int steps);
        int u0;
        u0 = upd_total;
        if (steps > 0) begin
            model_idx[ch]   = model_idx[ch] + 2'd1;
            model_color[ch] = PRESET_REF[model_idx[ch]];
        end
        channel = ch;
        button  = 1'b1;
        repeat (hold) @(negedge clk);
        button = 1'b0;
        // release has to settle before the next press
        repeat (DEBOUNCE_CYCLES + 8) @(negedge clk);
        check("color_update pulse count", 32'(upd_total - u0), 32'(steps));
        if (steps > 0) begin
            check("color_update", 32'(upd_last), 32'(4'b0001 << ch));
        end
        check_colors();
    endtask

    task automatic duty_frame();
        int high_r [4];
        int high_g [4];
        int high_b [4];
        for (int i = 0; i < 4; i++) begin
            high_r[i] = 0;
            high_g[i] = 0;
            high_b[i] = 0;
        end
        while (!i_dut.frame_start) @(negedge clk);
        // pins lag the counter by one register
        for (int k = 0; k < 256; k++) begin
            @(negedge clk);
            for (int i = 0; i < 4; i++) begin
                high_r[i] = high_r[i] + int'(led_r[i]);
                high_g[i] = high_g[i] + int'(led_g[i]);
                high_b[i] = high_b[i] + int'(led_b[i]);
            end
        end
        for (int i = 0; i < 4; i++) begin
            check($sformatf("led_r[%0d] high", i), 32'(high_r[i]), 32'(model_color[i][23:16]));
            check($sformatf("led_g[%0d] high", i), 32'(high_g[i]), 32'(model_color[i][15:8]));
            check($sformatf("led_b[%0d] high", i), 32'(high_b[i]), 32'(model_color[i][7:0]));
        end
    endtask

    initial begin
        rst       = 1'b1;
        button    = 1'b0;
        cmd_valid = 1'b0;
        channel   = 2'd0;
        address   = 4'd0;
        data      = 4'd0;
        lfsr      = 32'h342a_d40f;
        for (int i = 0; i < 4; i++) begin
            model_color[i] = PRESET_REF[i];
            model_idx[i]   = 2'(i);
        end
        repeat (5) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        test_bad = 1'b0;
        check("cmd_ack", 32'(cmd_ack), 32'd0);
        check("color_update", 32'(color_update), 32'd0);
        check_colors();
        $display("test reset state %s", test_bad ? "failed" : "ok");
        if (test_bad) tests_failed++;
        for (int n = 0; n < NUM_ENTRIES; n++) begin
            entry    = STIM[n];
            test_bad = 1'b0;
            case (entry[12:11])
                K_CMD: begin
                    cmd_data = entry[10] ? rand_nibble() : entry[3:0];
                    do_command(entry[9:8], entry[7:4], cmd_data);
                end
                K_PRESS:  run_button(entry[9:8], 12, 1);
                K_GLITCH: run_button(entry[9:8], 4, 0);
                default:  duty_frame();
            endcase
            $display("test %0d %s ch%0d %s", n, kind_name(entry[12:11]), entry[9:8],
                     test_bad ? "failed" : "ok");
            if (test_bad) tests_failed++;
        end
        $display("%0d tests run, %0d failed", NUM_ENTRIES + 1, tests_failed);
        if (tests_failed == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule
